/* Bender.yml */
package:
  name: any1_decode_stage

sources:
  - any1_decode_pkg.sv
  - fetch_capture.sv
  - inst_queue.sv
  - inst_decoder.sv
  - any1_decode_stage.sv
  - target: test
    files:
      - any1_decode_stage_tb.sv

/* any1_decode_pkg.sv */
// Shared widths, opcode and function encodings and the instruction word views for decode

package any1_decode_pkg;

	// ======================================================================
	// Widths
	// ======================================================================

	// Data and address width of the core
	localparam int XLEN = 64;

	// Instruction word width
	localparam int INSN_W = 40;

	// Register specifier width
	localparam int REG_W = 6;

	typedef logic [XLEN-1:0] address_t;

	// ======================================================================
	// Major opcodes
	// ======================================================================

	// Only the scalar integer, branch and memory groups are listed
	typedef enum logic [7:0] {
		NOP   = 8'h00,
		BRK   = 8'h01,
		R1    = 8'h02,
		R2    = 8'h03,
		ADDI  = 8'h04,
		ANDI  = 8'h08,
		ORI   = 8'h09,
		XORI  = 8'h0A,
		SLTUI = 8'h0F,
		MULI  = 8'h16,
		DIVUI = 8'h1B,
		JAL   = 8'h40,
		BEQ   = 8'h48,
		BLTU  = 8'h4C,
		LDx   = 8'h60,
		STx   = 8'h70
	} opcode_e;

	// ======================================================================
	// Function codes for the R1 and R2 groups
	// ======================================================================

	// The R1 and R2 groups share one function field and the opcode tells
	// them apart, so some codes repeat between the two groups
	typedef enum logic [5:0] {
		ABS  = 6'h00,
		NOT  = 6'h02,
		ADD  = 6'h04,
		SUB  = 6'h05,
		AND  = 6'h08,
		OR   = 6'h09,
		XOR  = 6'h0A,
		MUL  = 6'h10,
		DIV  = 6'h14,
		SLLI = 6'h20,
		SLTU = 6'h2C
	} func_e;

	// CTPOP is an R1 function with the same encoding as SUB in R2
	localparam func_e CTPOP = func_e'(6'h05);

	// ======================================================================
	// Instruction word formats
	// ======================================================================

	// Register to register format, also used for the immediate groups
	// where bits 35..20 carry the constant
	typedef struct packed {
		logic [7:0]       unused;
		func_e            func;
		logic [REG_W-1:0] rb;
		logic [REG_W-1:0] ra;
		logic [REG_W-1:0] rt;
		opcode_e          opcode;
	} r2_fmt_t;

	// Load format with a 12 bit displacement
	typedef struct packed {
		logic [7:0]       unused;
		logic [11:0]      disp;
		logic [REG_W-1:0] ra;
		logic [REG_W-1:0] rt;
		opcode_e          opcode;
	} ld_fmt_t;

	// Store format, the displacement is split around the rb field
	typedef struct packed {
		logic [7:0]       unused;
		logic [5:0]       disphi;
		logic [REG_W-1:0] rb;
		logic [REG_W-1:0] ra;
		logic [5:0]       displo;
		opcode_e          opcode;
	} st_fmt_t;

	// One instruction word read through whichever view the opcode selects
	typedef union packed {
		r2_fmt_t r2_fmt;
		ld_fmt_t ld_fmt;
		st_fmt_t st_fmt;
	} insn_u;

endpackage

/* any1_decode_stage.f */
any1_decode_pkg.sv
fetch_capture.sv
inst_queue.sv
inst_decoder.sv
any1_decode_stage.sv
any1_decode_stage_tb.sv

/* any1_decode_stage.sv */
// Decode stage top level joining fetch capture, instruction queue and decoder

`timescale 1ns/1ps

module any1_decode_stage import any1_decode_pkg::*; #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             fetch_req,
	input  insn_u            fetch_ir,
	input  address_t         fetch_ip,
	output logic             fetch_ack,
	output logic             dec_req,
	input  logic             dec_ack,
	output address_t         dec_ip,
	output insn_u            dec_ir,
	output logic [REG_W-1:0] dec_rt,
	output logic [REG_W-1:0] dec_ra,
	output logic [REG_W-1:0] dec_rb,
	output logic [XLEN-1:0]  dec_imm,
	output logic             dec_rfwr,
	output logic             dec_ui,
	output logic             dec_need_rb,
	output logic             dec_mc,
	output logic             dec_is_signed,
	output logic             dec_branch,
	output logic             dec_mem_op
);

	// Producer side of the queue
	logic     push;
	insn_u    push_ir;
	address_t push_ip;
	logic     full;

	// Consumer side of the queue
	logic     pop;
	logic     empty;
	insn_u    head_ir;
	address_t head_ip;

	fetch_capture u_capture (
		.clk       (clk),
		.rst_n     (rst_n),
		.fetch_req (fetch_req),
		.fetch_ir  (fetch_ir),
		.fetch_ip  (fetch_ip),
		.full      (full),
		.fetch_ack (fetch_ack),
		.push      (push),
		.push_ir   (push_ir),
		.push_ip   (push_ip)
	);

	inst_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_queue (
		.clk     (clk),
		.rst_n   (rst_n),
		.push    (push),
		.push_ir (push_ir),
		.push_ip (push_ip),
		.pop     (pop),
		.full    (full),
		.empty   (empty),
		.head_ir (head_ir),
		.head_ip (head_ip)
	);

	inst_decoder u_decoder (
		.clk           (clk),
		.rst_n         (rst_n),
		.empty         (empty),
		.head_ir       (head_ir),
		.head_ip       (head_ip),
		.dec_ack       (dec_ack),
		.pop           (pop),
		.dec_req       (dec_req),
		.dec_ip        (dec_ip),
		.dec_ir        (dec_ir),
		.dec_rt        (dec_rt),
		.dec_ra        (dec_ra),
		.dec_rb        (dec_rb),
		.dec_imm       (dec_imm),
		.dec_rfwr      (dec_rfwr),
		.dec_ui        (dec_ui),
		.dec_need_rb   (dec_need_rb),
		.dec_mc        (dec_mc),
		.dec_is_signed (dec_is_signed),
		.dec_branch    (dec_branch),
		.dec_mem_op    (dec_mem_op)
	);

endmodule

/* any1_decode_stage_tb.sv */
// Testbench for the decode stage with random fetch traffic, a decode reference model and checks

`timescale 1ns/1ps

module any1_decode_stage_tb import any1_decode_pkg::*;;

	localparam int QUEUE_DEPTH = 4;
	localparam int CLK_PERIOD = 20;
	localparam int NUM_INSNS = 300;
	localparam int WATCHDOG_CYCLES = NUM_INSNS * 40 + 200;
	localparam logic [31:0] SEED = 32'd9429;
	localparam int NUM_FIELDS = 13;
	localparam int BUNDLE_W = 2 * XLEN + INSN_W + 3 * REG_W + 7;

	logic             clk = 1'b0;
	logic             rst_n;
	logic             fetch_req;
	insn_u            fetch_ir;
	address_t         fetch_ip;
	logic             fetch_ack;
	logic             dec_req;
	logic             dec_ack;
	address_t         dec_ip;
	insn_u            dec_ir;
	logic [REG_W-1:0] dec_rt;
	logic [REG_W-1:0] dec_ra;
	logic [REG_W-1:0] dec_rb;
	logic [XLEN-1:0]  dec_imm;
	logic             dec_rfwr;
	logic             dec_ui;
	logic             dec_need_rb;
	logic             dec_mc;
	logic             dec_is_signed;
	logic             dec_branch;
	logic             dec_mem_op;

	logic [31:0]         fetch_rng;
	logic [31:0]         ack_rng;
	logic [BUNDLE_W-1:0] exp_q [$];
	logic [BUNDLE_W-1:0] bundle_now;
	logic [BUNDLE_W-1:0] bundle_q;
	logic                fetch_req_q;
	logic                fetch_ack_q;
	logic                dec_req_q;
	logic                dec_ack_q;
	logic                req_seen;
	int                  accepted_count;
	int                  acked_count;
	int                  peak_outstanding;

	any1_decode_stage #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) dut_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.fetch_req     (fetch_req),
		.fetch_ir      (fetch_ir),
		.fetch_ip      (fetch_ip),
		.fetch_ack     (fetch_ack),
		.dec_req       (dec_req),
		.dec_ack       (dec_ack),
		.dec_ip        (dec_ip),
		.dec_ir        (dec_ir),
		.dec_rt        (dec_rt),
		.dec_ra        (dec_ra),
		.dec_rb        (dec_rb),
		.dec_imm       (dec_imm),
		.dec_rfwr      (dec_rfwr),
		.dec_ui        (dec_ui),
		.dec_need_rb   (dec_need_rb),
		.dec_mc        (dec_mc),
		.dec_is_signed (dec_is_signed),
		.dec_branch    (dec_branch),
		.dec_mem_op    (dec_mem_op)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Field order here matches the reference model result
	assign bundle_now = {dec_ip, dec_ir, dec_rt, dec_ra, dec_rb, dec_imm, dec_rfwr, dec_ui,
		dec_need_rb, dec_mc, dec_is_signed, dec_branch, dec_mem_op};

	// ======================================================================
	// Error reporting
	// ======================================================================

	task automatic abort_run();
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [XLEN-1:0] got,
			input logic [XLEN-1:0] exp);
		$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		abort_run();
	endtask

	task automatic report_problem(input string what);
		$display("ERROR: %s", what);
		abort_run();
	endtask

	// ======================================================================
	// Random stimulus
	// ======================================================================

	function automatic logic [31:0] lcg_step(inout logic [31:0] state);
		state = state * 32'd1664525 + 32'd1013904223;
		return state;
	endfunction

	// Kept opcodes plus four codes the decoder does not know
	function automatic logic [7:0] pick_opcode(input int unsigned k);
		case (k % 20)
			0: return NOP;
			1: return BRK;
			2: return R1;
			3: return R2;
			4: return ADDI;
			5: return ANDI;
			6: return ORI;
			7: return XORI;
			8: return SLTUI;
			9: return MULI;
			10: return DIVUI;
			11: return JAL;
			12: return BEQ;
			13: return BLTU;
			14: return LDx;
			15: return STx;
			16: return 8'h05;
			17: return 8'h3F;
			18: return 8'h7F;
			default: return 8'hFF;
		endcase
	endfunction

	function automatic logic [5:0] pick_func(input int unsigned k);
		case (k % 13)
			0: return ABS;
			1: return NOT;
			2: return CTPOP;
			3: return ADD;
			4: return AND;
			5: return OR;
			6: return XOR;
			7: return MUL;
			8: return DIV;
			9: return SLLI;
			10: return SLTU;
			11: return 6'h11;
			default: return 6'h3F;
		endcase
	endfunction

	function automatic logic [INSN_W-1:0] random_word(inout logic [31:0] rng);
		logic [INSN_W-1:0] w;
		logic [31:0]       r;
		r = lcg_step(rng);
		w[INSN_W-1:8] = r;
		r = lcg_step(rng);
		w[7:0] = pick_opcode(r[31:16]);
		r = lcg_step(rng);
		if (w[7:0] == R1 || w[7:0] == R2) begin
			w[31:26] = pick_func(r[31:16]);
		end
		return w;
	endfunction

	// Mostly short waits, with an occasional stall long enough to fill the queue
	function automatic int pick_ack_delay(inout logic [31:0] rng);
		logic [31:0] r;
		r = lcg_step(rng);
		if (r[31:29] == 3'd0) begin
			return 30 + int'(r[27:24]);
		end
		return int'(r[27:26]);
	endfunction

	// ======================================================================
	// Reference decode
	// ======================================================================

	function automatic logic [BUNDLE_W-1:0] ref_decode(input logic [INSN_W-1:0] w,
			input address_t ip);
		logic [7:0]       op;
		logic [5:0]       fn;
		logic [15:0]      k;
		logic [REG_W-1:0] rt;
		logic [REG_W-1:0] ra;
		logic [REG_W-1:0] rb;
		logic [XLEN-1:0]  imm;
		logic             rfwr;
		logic             ui;
		logic             need_rb;
		logic             mc;
		logic             is_signed;
		logic             branch;
		logic             mem_op;
		op = w[7:0];
		fn = w[31:26];
		k = w[35:20];
		rt = '0;
		ra = w[19:14];
		rb = w[25:20];
		imm = '0;
		rfwr = 1'b0;
		ui = 1'b1;
		need_rb = 1'b0;
		mc = 1'b0;
		is_signed = 1'b1;
		branch = 1'b0;
		mem_op = 1'b0;
		case (op)
			NOP, BRK: ui = 1'b0;
			R1: begin
				if (fn == ABS || fn == NOT || fn == CTPOP) begin
					rt = w[13:8];
					rfwr = 1'b1;
					ui = 1'b0;
				end
			end
			R2: begin
				need_rb = 1'b1;
				if (fn inside {ADD, SUB, AND, OR, XOR, MUL, DIV, SLLI, SLTU}) begin
					rt = w[13:8];
					rfwr = 1'b1;
					ui = 1'b0;
					mc = (fn == MUL) || (fn == DIV);
					is_signed = (fn != SLTU);
					imm = (fn == SLLI) ? XLEN'(rb) : '0;
				end
			end
			ADDI, MULI, ANDI, ORI, XORI, SLTUI, DIVUI: begin
				rt = w[13:8];
				rfwr = 1'b1;
				ui = 1'b0;
				mc = (op == MULI) || (op == DIVUI);
				is_signed = !(op == SLTUI || op == DIVUI);
				if (op == ADDI || op == MULI) begin
					imm = XLEN'($signed(k));
				end else if (op == ANDI) begin
					imm = {{(XLEN-16){1'b1}}, k};
				end else begin
					imm = XLEN'(k);
				end
			end
			JAL: begin
				rt = REG_W'(w[9:8]);
				imm = XLEN'($signed(w[35:10]));
				rfwr = 1'b1;
				mc = 1'b1;
				ui = 1'b0;
			end
			BEQ, BLTU: begin
				imm = XLEN'($signed({w[35:28], w[13:8]}));
				branch = 1'b1;
				need_rb = 1'b1;
				mc = 1'b1;
				ui = 1'b0;
				is_signed = (op != BLTU);
			end
			LDx: begin
				rt = w[13:8];
				rfwr = 1'b1;
				mc = 1'b1;
				mem_op = 1'b1;
				imm = XLEN'($signed(w[31:20]));
				ui = 1'b0;
			end
			STx: begin
				need_rb = 1'b1;
				mc = 1'b1;
				mem_op = 1'b1;
				imm = XLEN'($signed({w[31:26], w[13:8]}));
				ui = 1'b0;
			end
			default: begin
			end
		endcase
		return {ip, w, rt, ra, rb, imm, rfwr, ui, need_rb, mc, is_signed, branch, mem_op};
	endfunction

	function automatic string field_label(input int idx);
		case (idx)
			0: return "dec_ip";
			1: return "dec_ir";
			2: return "dec_rt";
			3: return "dec_ra";
			4: return "dec_rb";
			5: return "dec_imm";
			6: return "dec_rfwr";
			7: return "dec_ui";
			8: return "dec_need_rb";
			9: return "dec_mc";
			10: return "dec_is_signed";
			11: return "dec_branch";
			default: return "dec_mem_op";
		endcase
	endfunction

	function automatic void split_bundle(input logic [BUNDLE_W-1:0] b,
			output logic [XLEN-1:0] f [NUM_FIELDS]);
		address_t          ip;
		logic [INSN_W-1:0] ir;
		logic [REG_W-1:0]  rt;
		logic [REG_W-1:0]  ra;
		logic [REG_W-1:0]  rb;
		logic [XLEN-1:0]   imm;
		logic [6:0]        flags;
		int                i;
		{ip, ir, rt, ra, rb, imm, flags} = b;
		f[0] = ip;
		f[1] = XLEN'(ir);
		f[2] = XLEN'(rt);
		f[3] = XLEN'(ra);
		f[4] = XLEN'(rb);
		f[5] = imm;
		for (i = 0; i < 7; i++) begin
			f[6+i] = XLEN'(flags[6-i]);
		end
	endfunction

	// Reports the first field, in port order, where the two bundles differ
	task automatic compare_bundles(input logic [BUNDLE_W-1:0] got,
			input logic [BUNDLE_W-1:0] exp);
		logic [XLEN-1:0] g [NUM_FIELDS];
		logic [XLEN-1:0] e [NUM_FIELDS];
		int              idx;
		int              i;
		split_bundle(got, g);
		split_bundle(exp, e);
		idx = -1;
		for (i = NUM_FIELDS - 1; i >= 0; i--) begin
			if (g[i] !== e[i]) begin
				idx = i;
			end
		end
		assert (idx < 0) else report_mismatch(field_label(idx), g[idx], e[idx]);
	endtask

	// ======================================================================
	// Checks, all on values sampled at the rising edge
	// ======================================================================

	always @(posedge clk) begin
		fetch_req_q <= fetch_req;
		fetch_ack_q <= fetch_ack;
		dec_req_q   <= dec_req;
		dec_ack_q   <= dec_ack;
		bundle_q    <= bundle_now;
		if (fetch_req) begin
			req_seen <= 1'b1;
		end
	end

	always @(posedge clk) begin
		if (rst_n && !req_seen) begin
			assert (!fetch_ack && !dec_req)
			else report_problem("fetch_ack or dec_req went high before any fetch request");
		end
	end

	// The edge that raised fetch_ack is the one before it is first seen high
	always @(posedge clk) begin
		if (rst_n && fetch_ack && !fetch_ack_q) begin
			assert (fetch_req_q) else report_problem("fetch_ack rose while fetch_req was low");
		end
	end

	always @(posedge clk) begin
		if (rst_n && !fetch_req && !fetch_req_q) begin
			assert (!fetch_ack) else report_problem("fetch_ack stayed high after fetch_req fell");
		end
	end

	// Queue plus the one bundle on offer is all the room there is
	always @(posedge clk) begin
		if (rst_n && fetch_ack && !fetch_ack_q) begin
			assert (accepted_count - acked_count <= QUEUE_DEPTH)
			else report_problem("fetch_ack rose although queue and decoder were full");
		end
	end

	always @(posedge clk) begin
		if (rst_n && dec_req_q && !dec_ack_q && dec_req) begin
			compare_bundles(bundle_now, bundle_q);
		end
	end

	always @(posedge clk) begin
		if (rst_n && dec_ack && dec_ack_q) begin
			assert (!dec_req) else report_problem("dec_req stayed high one cycle after dec_ack");
		end
	end

	always @(posedge clk) begin
		if (rst_n && dec_ack && !dec_ack_q) begin
			assert (exp_q.size() != 0) begin
				compare_bundles(bundle_now, exp_q.pop_front());
			end else begin
				report_problem("A bundle was acknowledged with no instruction outstanding");
			end
		end
	end

	always @(posedge clk) begin
		if (rst_n && fetch_ack && !fetch_ack_q) begin
			accepted_count <= accepted_count + 1;
			if (accepted_count - acked_count + 1 > peak_outstanding) begin
				peak_outstanding <= accepted_count - acked_count + 1;
			end
		end
		if (rst_n && dec_ack && !dec_ack_q) begin
			acked_count <= acked_count + 1;
		end
	end

	// ======================================================================
	// Fetch side, reset and end of run
	// ======================================================================

	initial begin : fetch_driver
		int                n;
		int                gap;
		logic [INSN_W-1:0] word;
		address_t          ip;
		rst_n = 1'b0;
		fetch_req = 1'b0;
		fetch_ir = '0;
		fetch_ip = '0;
		dec_ack = 1'b0;
		fetch_rng = SEED;
		ack_rng = SEED ^ 32'h5A5A_5A5A;
		fetch_req_q = 1'b0;
		fetch_ack_q = 1'b0;
		dec_req_q = 1'b0;
		dec_ack_q = 1'b0;
		bundle_q = '0;
		req_seen = 1'b0;
		accepted_count = 0;
		acked_count = 0;
		peak_outstanding = 0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		repeat (3) @(posedge clk);
		for (n = 0; n < NUM_INSNS; n++) begin
			word = random_word(fetch_rng);
			ip = {lcg_step(fetch_rng), lcg_step(fetch_rng)};
			exp_q.push_back(ref_decode(word, ip));
			fetch_ir  <= word;
			fetch_ip  <= ip;
			fetch_req <= 1'b1;
			do @(posedge clk); while (!fetch_ack);
			fetch_req <= 1'b0;
			// The word may change once the transfer is acknowledged
			fetch_ir  <= random_word(fetch_rng);
			do @(posedge clk); while (fetch_ack);
			gap = int'(lcg_step(fetch_rng) >> 30) % 3;
			repeat (gap) @(posedge clk);
		end
		wait (acked_count == NUM_INSNS);
		repeat (4) @(posedge clk);
		if (dec_req || fetch_ack) begin
			report_problem("Handshake still active after every instruction was acknowledged");
		end else if (peak_outstanding != QUEUE_DEPTH + 1) begin
			report_problem($sformatf("Peak of %0d outstanding transfers, queue never filled",
				peak_outstanding));
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

	// Issue side acknowledges each offered bundle after a random wait
	initial begin : ack_driver
		int hold;
		wait (rst_n === 1'b1);
		forever begin
			do @(posedge clk); while (!dec_req);
			hold = pick_ack_delay(ack_rng);
			repeat (hold) @(posedge clk);
			dec_ack <= 1'b1;
			do @(posedge clk); while (dec_req);
			dec_ack <= 1'b0;
		end
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		report_problem($sformatf("Timeout after %0d cycles with %0d of %0d bundles acknowledged",
			WATCHDOG_CYCLES, acked_count, NUM_INSNS));
	end

endmodule

/* fetch_capture.sv */
// Fetch capture stage that acknowledges fetch requests and pushes each word into the queue

`timescale 1ns/1ps

module fetch_capture import any1_decode_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     fetch_req,
	input  insn_u    fetch_ir,
	input  address_t fetch_ip,
	input  logic     full,
	output logic     fetch_ack,
	output logic     push,
	output insn_u    push_ir,
	output address_t push_ip
);

	localparam logic WAIT_REQ = 1'b0;
	localparam logic WAIT_REL = 1'b1;

	logic state;
	logic take;

	// A new request is taken only while the queue has room for it
	assign take = (state == WAIT_REQ) && fetch_req && !full;

	// Acknowledge is held from the capture until the request is dropped
	assign fetch_ack = (state == WAIT_REL);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= WAIT_REQ;
			push  <= 1'b0;
		end else begin
			// One push per transfer, issued the cycle after the capture
			push <= take;
			case (state)
				WAIT_REQ: begin
					if (take) begin
						state <= WAIT_REL;
					end
				end
				WAIT_REL: begin
					if (!fetch_req) begin
						state <= WAIT_REQ;
					end
				end
				default: begin
					state <= WAIT_REQ;
				end
			endcase
		end
	end

	// Word and address are held here until the queue writes them
	always_ff @(posedge clk) begin
		if (take) begin
			push_ir <= fetch_ir;
			push_ip <= fetch_ip;
		end
	end

endmodule

/* inst_decoder.sv */
// Instruction decoder that pops the queue, decodes the head and offers the bundle to issue

`timescale 1ns/1ps

module inst_decoder import any1_decode_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             empty,
	input  insn_u            head_ir,
	input  address_t         head_ip,
	input  logic             dec_ack,
	output logic             pop,
	output logic             dec_req,
	output address_t         dec_ip,
	output insn_u            dec_ir,
	output logic [REG_W-1:0] dec_rt,
	output logic [REG_W-1:0] dec_ra,
	output logic [REG_W-1:0] dec_rb,
	output logic [XLEN-1:0]  dec_imm,
	output logic             dec_rfwr,
	output logic             dec_ui,
	output logic             dec_need_rb,
	output logic             dec_mc,
	output logic             dec_is_signed,
	output logic             dec_branch,
	output logic             dec_mem_op
);

	localparam logic [1:0] IDLE    = 2'd0;
	localparam logic [1:0] OFFER   = 2'd1;
	localparam logic [1:0] RELEASE = 2'd2;

	logic [1:0]       state;
	logic [15:0]      imm16;
	logic [REG_W-1:0] d_rt;
	logic [REG_W-1:0] d_ra;
	logic [REG_W-1:0] d_rb;
	logic [XLEN-1:0]  d_imm;
	logic             d_rfwr;
	logic             d_ui;
	logic             d_need_rb;
	logic             d_mc;
	logic             d_is_signed;
	logic             d_branch;
	logic             d_mem_op;
	logic             wr_rt;

	// ======================================================================
	// Combinational decode of the queue head
	// ======================================================================

	// Immediate groups carry a 16 bit constant above the ra field
	assign imm16 = head_ir[35:20];

	always_comb begin
		d_rt        = '0;
		d_ra        = head_ir.r2_fmt.ra;
		d_rb        = head_ir.r2_fmt.rb;
		d_imm       = '0;
		d_rfwr      = 1'b0;
		d_ui        = 1'b1;
		d_need_rb   = 1'b0;
		d_mc        = 1'b0;
		d_is_signed = 1'b1;
		d_branch    = 1'b0;
		d_mem_op    = 1'b0;
		// Set for every form that writes the rt field of the register file
		wr_rt       = 1'b0;

		case (head_ir.r2_fmt.opcode)
			NOP, BRK: begin
				d_ui = 1'b0;
			end
			R1: begin
				case (head_ir.r2_fmt.func)
					ABS, NOT, CTPOP: begin
						wr_rt = 1'b1;
					end
					default: begin
					end
				endcase
			end
			R2: begin
				d_need_rb = 1'b1;
				case (head_ir.r2_fmt.func)
					ADD, SUB, AND, OR, XOR: begin
						wr_rt = 1'b1;
					end
					MUL, DIV: begin
						wr_rt = 1'b1;
						d_mc  = 1'b1;
					end
					SLLI: begin
						wr_rt = 1'b1;
						// Shift amount sits in the rb field
						d_imm = {{(XLEN-REG_W){1'b0}}, head_ir.r2_fmt.rb};
					end
					SLTU: begin
						wr_rt       = 1'b1;
						d_is_signed = 1'b0;
					end
					default: begin
					end
				endcase
			end
			ADDI, MULI: begin
				wr_rt = 1'b1;
				d_imm = {{(XLEN-16){imm16[15]}}, imm16};
				d_mc  = (head_ir.r2_fmt.opcode == MULI);
			end
			ANDI: begin
				// Upper bits are ones so the mask leaves them untouched
				wr_rt = 1'b1;
				d_imm = {{(XLEN-16){1'b1}}, imm16};
			end
			ORI, XORI, SLTUI, DIVUI: begin
				wr_rt = 1'b1;
				d_imm = {{(XLEN-16){1'b0}}, imm16};
				if (head_ir.r2_fmt.opcode == SLTUI || head_ir.r2_fmt.opcode == DIVUI) begin
					d_is_signed = 1'b0;
				end
				d_mc = (head_ir.r2_fmt.opcode == DIVUI);
			end
			JAL: begin
				// Link register is one of the first four
				d_rt   = {{(REG_W-2){1'b0}}, head_ir[9:8]};
				d_imm  = {{(XLEN-26){head_ir[35]}}, head_ir[35:10]};
				d_rfwr = 1'b1;
				d_mc   = 1'b1;
				d_ui   = 1'b0;
			end
			BEQ, BLTU: begin
				d_imm       = {{(XLEN-14){head_ir[35]}}, head_ir[35:28], head_ir[13:8]};
				d_branch    = 1'b1;
				d_need_rb   = 1'b1;
				d_mc        = 1'b1;
				d_ui        = 1'b0;
				d_is_signed = (head_ir.r2_fmt.opcode != BLTU);
			end
			LDx: begin
				d_rt     = head_ir.ld_fmt.rt;
				d_rfwr   = 1'b1;
				d_mc     = 1'b1;
				d_mem_op = 1'b1;
				d_imm    = {{(XLEN-12){head_ir.ld_fmt.disp[11]}}, head_ir.ld_fmt.disp};
				d_ui     = 1'b0;
			end
			STx: begin
				d_need_rb = 1'b1;
				d_mc      = 1'b1;
				d_mem_op  = 1'b1;
				d_imm     = {{(XLEN-12){head_ir.st_fmt.disphi[5]}},
					head_ir.st_fmt.disphi, head_ir.st_fmt.displo};
				d_ui      = 1'b0;
			end
			default: begin
			end
		endcase

		if (wr_rt) begin
			d_rt   = head_ir.r2_fmt.rt;
			d_rfwr = 1'b1;
			d_ui   = 1'b0;
		end
	end

	// ======================================================================
	// Issue handshake
	// ======================================================================

	// Pop only when both handshake lines are low
	assign pop     = (state == IDLE) && !empty && !dec_ack;
	assign dec_req = (state == OFFER);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (pop) begin
						state <= OFFER;
					end
				end
				OFFER: begin
					if (dec_ack) begin
						state <= RELEASE;
					end
				end
				RELEASE: begin
					if (!dec_ack) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Bundle is loaded with the pop and held for the whole offer
	always_ff @(posedge clk) begin
		if (pop) begin
			dec_ip        <= head_ip;
			dec_ir        <= head_ir;
			dec_rt        <= d_rt;
			dec_ra        <= d_ra;
			dec_rb        <= d_rb;
			dec_imm       <= d_imm;
			dec_rfwr      <= d_rfwr;
			dec_ui        <= d_ui;
			dec_need_rb   <= d_need_rb;
			dec_mc        <= d_mc;
			dec_is_signed <= d_is_signed;
			dec_branch    <= d_branch;
			dec_mem_op    <= d_mem_op;
		end
	end

endmodule

/* inst_queue.sv */
// Instruction queue, a circular FIFO of instruction words and their addresses

`timescale 1ns/1ps

module inst_queue import any1_decode_pkg::*; #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     push,
	input  insn_u    push_ir,
	input  address_t push_ip,
	input  logic     pop,
	output logic     full,
	output logic     empty,
	output insn_u    head_ir,
	output address_t head_ip
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(QUEUE_DEPTH - 1);
	localparam logic [CNT_W-1:0] MAX_CNT = CNT_W'(QUEUE_DEPTH);

	insn_u            mem_ir [QUEUE_DEPTH];
	address_t         mem_ip [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	assign full  = (count == MAX_CNT);
	assign empty = (count == '0);

	// Oldest entry is always presented at the head
	assign head_ir = mem_ir[rd_ptr];
	assign head_ip = mem_ip[rd_ptr];

	// Pointers wrap at the last slot so any depth works
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: begin
					count <= count + 1'b1;
				end
				2'b01: begin
					count <= count - 1'b1;
				end
				default: begin
					count <= count;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem_ir[wr_ptr] <= push_ir;
			mem_ip[wr_ptr] <= push_ip;
		end
	end

endmodule
